/* pio_req.f */
+incdir+verilog
verilog/pio_pkg.sv
verilog/pio_accept.sv
verilog/pio_queue.sv
verilog/pio_issue.sv
verilog/pio_req_top.sv
bench/pio_req_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the PIO request path testbench with Verilator, run it, scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f pio_req.f --top-module pio_req_tb -o pio_req_sim
./obj_dir/pio_req_sim > sim.log 2>&1
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
   exit 1
fi
exit 0

/* bench/pio_req_tb.sv */
// PIO request path testbench with random requests, scoreboard, CSR and throttle checks
`timescale 1ns/1ps
`default_nettype none
`include "pio_macros.svh"

module pio_req_tb import pio_pkg::*; ();

   localparam int HALF_NS    = 20;
   localparam int SAMPLE_DLY = 10;
   localparam int N_RD       = 40;
   localparam int N_MIX      = 24;
   localparam int N_CSR      = 12;
   // Queued and CSR requests over all tests
   localparam int N_REQ      = N_RD + N_MIX + N_CSR * 2 + 16 + 5;
   localparam int WDOG_CYC   = N_REQ * 400 + 2000;
   localparam int ACC_LIMIT  = 400;
   localparam int ISS_LIMIT  = 400;

   // Scoreboard entry for a header or write data beat
   typedef struct packed {
      logic     is_data;
      pio_out_t o;
   } exp_t;

   logic                       clk = 1'b0;
   logic                       rst;
   logic [3:0]                 max_pio;
   logic                       rd_vld;
   logic                       wr_vld;
   ucb_req_t                   req;
   logic                       req_accepted;
   logic                       csr_wr;
   csr_wr_t                    csr_wr_bus;
   logic [`PIO_CSR_ADDR_W-1:0] csr_rd_addr;
   logic                       csr_rd_ack;
   logic [`PIO_THR_W-1:0]      csr_ack_thr;
   logic [`PIO_BUF_W-1:0]      csr_ack_buf;
   logic                       pio_pop = 1'b0;
   logic                       rd_done = 1'b0;
   logic                       pio_req;
   logic                       pio_data_vld;
   pio_out_t                   pio_out;

   int   seed = 92513;
   exp_t exp_q[$];
   logic cons_en = 1'b0;
   logic auto_done = 1'b0;
   logic want_data = 1'b0;
   int   done_owed = 0;
   int   rd_issued = 0;
   int   wr_issued = 0;
   int   csr_wr_sent = 0;
   int   csr_rd_sent = 0;
   int   csr_wr_seen = 0;
   int   csr_ack_seen = 0;
   int   mis_errs = 0;
   int   other_errs = 0;

   pio_req_top pio_req_top_inst (
      .clk          (clk),
      .rst          (rst),
      .max_pio      (max_pio),
      .rd_vld       (rd_vld),
      .wr_vld       (wr_vld),
      .req          (req),
      .req_accepted (req_accepted),
      .csr_wr       (csr_wr),
      .csr_wr_bus   (csr_wr_bus),
      .csr_rd_addr  (csr_rd_addr),
      .csr_rd_ack   (csr_rd_ack),
      .csr_ack_thr  (csr_ack_thr),
      .csr_ack_buf  (csr_ack_buf),
      .pio_pop      (pio_pop),
      .rd_done      (rd_done),
      .pio_req      (pio_req),
      .pio_data_vld (pio_data_vld),
      .pio_out      (pio_out)
   );

   always #(HALF_NS) clk = ~clk;

   // ********************
   // Reference model
   // ********************
   function automatic pio_out_t expect_hdr(input logic is_rd, input ucb_req_t r);
      pio_out_t              o;
      logic [`PIO_MAP_W-1:0] m;
      logic [7:0]            lane;
      o        = '0;
      o.rw     = is_rd;
      o.thr_id = r.thr_id;
      o.buf_id = r.buf_id;
      if (r.addr[39:32] != 8'h80) begin
         m = (43'h7 << 40) | 43'(r.addr);
         if (r.addr[39:38] != 2'b11)
            o.dest = `PIO_DEST_OTH;
         else
            o.dest = r.addr[37] ? `PIO_DEST_5 : `PIO_DEST_4;
      end else if (r.addr[31:28] != 4'h0) begin
         m      = (43'h600 << 32) | 43'(r.addr[31:0]);
         o.dest = `PIO_DEST_0;
      end else begin
         m = (43'h4000 << 28) | 43'(r.addr[27:0]);
         case (r.addr[27:24])
            4'hE:    o.dest = `PIO_DEST_4;
            4'hF:    o.dest = `PIO_DEST_5;
            default: o.dest = `PIO_DEST_OTH;
         endcase
      end
      o.ad = 64'(m);
      // Size gives the run of bytes and address low bits its offset
      case (r.size)
         `PIO_SIZE_1B: lane = 8'h01;
         `PIO_SIZE_2B: lane = 8'h03;
         `PIO_SIZE_4B: lane = 8'h0f;
         default:      lane = 8'hff;
      endcase
      lane = lane << m[2:0];
      if (r.size == `PIO_SIZE_16B)
         o.be = 16'hffff;
      else if (r.addr[3])
         o.be = {lane, 8'h00};
      else
         o.be = {8'h00, lane};
      return o;
   endfunction

   // Region 0 CSR window, 1 low 0x80 space, 2 rest of 0x80, 3 elsewhere
   function automatic ucb_req_t rand_req(input int region);
      ucb_req_t r;
      int       pick;
      r.thr_id = 5'($random(seed));
      r.buf_id = 2'($random(seed));
      r.size   = 3'($unsigned($random(seed)) % 5);
      r.data   = {32'($random(seed)), 32'($random(seed))};
      r.addr   = {8'($random(seed)), 32'($random(seed))};
      pick     = int'($unsigned($random(seed)) % 4);
      case (region)
         0: r.addr[39:24] = 16'h8000;
         1: begin
            r.addr[39:28] = 12'h800;
            if (pick == 0)
               r.addr[27:24] = 4'hE;
            else if (pick == 1)
               r.addr[27:24] = 4'hF;
            else
               r.addr[27:24] = 4'(32'd1 + ($unsigned($random(seed)) % 13));
         end
         2: begin
            r.addr[39:32] = 8'h80;
            if (r.addr[31:28] == 4'h0)
               r.addr[31:28] = 4'h3;
         end
         default: begin
            if (r.addr[39:32] == 8'h80)
               r.addr[39:32] = 8'hC0;
         end
      endcase
      return r;
   endfunction

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         mis_errs++;
         $display("MISMATCH at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      end
   endtask

   // ********************
   // Request side
   // ********************
   task automatic queue_expect(input logic is_rd, input ucb_req_t r);
      exp_t e;
      e.is_data = 1'b0;
      e.o       = expect_hdr(is_rd, r);
      exp_q.push_back(e);
      if (!is_rd) begin
         e.is_data = 1'b1;
         e.o       = '0;
         e.o.ad    = r.data;
         exp_q.push_back(e);
      end
   endtask

   task automatic drive_req(input logic is_rd, input ucb_req_t r);
      @(negedge clk);
      rd_vld = is_rd;
      wr_vld = ~is_rd;
      req    = r;
   endtask

   // Called on a falling edge and returns mid-cycle
   task automatic wait_accept(input int limit, output logic ok);
      int n;
      n = 0;
      #(SAMPLE_DLY);
      while (!req_accepted && n < limit) begin
         @(negedge clk);
         #(SAMPLE_DLY);
         n++;
      end
      ok = req_accepted;
   endtask

   // Drops the request on a falling edge and returns mid-cycle
   task automatic release_req();
      @(negedge clk);
      rd_vld = 1'b0;
      wr_vld = 1'b0;
      #(SAMPLE_DLY);
   endtask

   task automatic send_req(input logic is_rd, input ucb_req_t r);
      logic ok;
      logic csr;
      csr = r.addr[39:24] == 16'h8000;
      if (!csr)
         queue_expect(is_rd, r);
      else if (is_rd)
         csr_rd_sent++;
      else
         csr_wr_sent++;
      drive_req(is_rd, r);
      wait_accept(ACC_LIMIT, ok);
      if (!ok) begin
         other_errs++;
         $display("%0t: request to 0x%0h was never accepted", $time, r.addr);
      end else if (csr && is_rd) begin
         check_val("csr_rd_ack", 64'(csr_rd_ack), 64'd1);
         check_val("csr_rd_addr", 64'(csr_rd_addr), 64'(r.addr[15:0]));
         check_val("csr_ack_thr", 64'(csr_ack_thr), 64'(r.thr_id));
         check_val("csr_ack_buf", 64'(csr_ack_buf), 64'(r.buf_id));
      end else if (csr) begin
         check_val("csr_wr", 64'(csr_wr), 64'd1);
         check_val("csr_wr_bus.addr", 64'(csr_wr_bus.addr), 64'(r.addr[15:0]));
         check_val("csr_wr_bus.data", 64'(csr_wr_bus.data), 64'(r.data[31:0]));
      end
      release_req();
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clk);
      #(SAMPLE_DLY);
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      wait_cycles(1);
      while ((exp_q.size() != 0 || want_data || done_owed != 0) && n < ISS_LIMIT) begin
         wait_cycles(1);
         n++;
      end
      if (n >= ISS_LIMIT) begin
         other_errs++;
         $display("%0t: egress did not drain, %0d words still expected", $time, exp_q.size());
      end
   endtask

   task automatic wait_issued(input int rd_t, input int wr_t);
      int n;
      n = 0;
      wait_cycles(1);
      while ((rd_issued < rd_t || wr_issued < wr_t) && n < ISS_LIMIT) begin
         wait_cycles(1);
         n++;
      end
      if (n >= ISS_LIMIT) begin
         other_errs++;
         $display("%0t: expected issue never happened", $time);
      end
   endtask

   // ********************
   // Consumer and compare
   // ********************
   always @(negedge clk) begin
      exp_t e;
      pio_pop = 1'b0;
      rd_done = 1'b0;
      if (done_owed > 0) begin
         rd_done = 1'b1;
         done_owed--;
      end
      // Random stalls on the consumer side
      if (cons_en && ($unsigned($random(seed)) % 4 != 0)) begin
         if (want_data) begin
            if (pio_data_vld) begin
               e = exp_q.pop_front();
               check_val("pio_req", 64'(pio_req), 64'(!e.is_data));
               check_val("pio_out.ad", pio_out.ad, e.o.ad);
               pio_pop   = 1'b1;
               want_data = 1'b0;
            end
         end else if (pio_req) begin
            pio_pop = 1'b1;
            if (exp_q.size() == 0) begin
               other_errs++;
               $display("%0t: header issued with nothing expected", $time);
            end else begin
               e = exp_q.pop_front();
               check_val("pio_data_vld", 64'(pio_data_vld), 64'(e.is_data));
               check_val("pio_out.rw", 64'(pio_out.rw), 64'(e.o.rw));
               check_val("pio_out.dest", 64'(pio_out.dest), 64'(e.o.dest));
               check_val("pio_out.be", 64'(pio_out.be), 64'(e.o.be));
               check_val("pio_out.ad", pio_out.ad, e.o.ad);
               check_val("pio_out.thr_id", 64'(pio_out.thr_id), 64'(e.o.thr_id));
               check_val("pio_out.buf_id", 64'(pio_out.buf_id), 64'(e.o.buf_id));
               if (e.o.rw) begin
                  rd_issued++;
                  if (auto_done)
                     done_owed++;
               end else begin
                  wr_issued++;
                  want_data = 1'b1;
               end
            end
         end
      end
   end

   // CSR strobe counts with one sample per cycle
   always @(negedge clk) begin
      #(SAMPLE_DLY);
      if (!rst && csr_wr)
         csr_wr_seen++;
      if (!rst && csr_rd_ack)
         csr_ack_seen++;
   end

   initial begin
      repeat (WDOG_CYC) @(posedge clk);
      $display("Watchdog expired after %0d cycles", WDOG_CYC);
      $display("RESULT: FAIL");
      $finish;
   end

   // ********************
   // Test sequence
   // ********************
   initial begin
      logic     ok;
      logic     is_rd;
      int       rd0;
      int       wr0;
      ucb_req_t r;
      rst     = 1'b1;
      max_pio = 4'd15;
      rd_vld  = 1'b0;
      wr_vld  = 1'b0;
      req     = '0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      wait_cycles(1);
      // Idle outputs after reset
      check_val("req_accepted", 64'(req_accepted), 64'd0);
      check_val("csr_wr", 64'(csr_wr), 64'd0);
      check_val("csr_rd_ack", 64'(csr_rd_ack), 64'd0);
      check_val("pio_req", 64'(pio_req), 64'd0);
      check_val("pio_data_vld", 64'(pio_data_vld), 64'd0);
      cons_en   = 1'b1;
      auto_done = 1'b1;

      // Reads over all queued regions
      for (int i = 0; i < N_RD; i++)
         send_req(1'b1, rand_req(1 + int'($unsigned($random(seed)) % 3)));
      wait_drain();

      // Mostly writes with a header then a data beat
      for (int i = 0; i < N_MIX; i++) begin
         is_rd = ($unsigned($random(seed)) % 4) == 0;
         send_req(is_rd, rand_req(1 + int'($unsigned($random(seed)) % 3)));
      end
      wait_drain();

      // CSR window mixed with queued reads
      for (int i = 0; i < N_CSR; i++) begin
         is_rd = 1'($random(seed));
         send_req(is_rd, rand_req(0));
         if (i % 3 == 0)
            send_req(1'b1, rand_req(3));
      end
      wait_drain();

      // Back-pressure with the consumer off until the queue fills
      cons_en = 1'b0;
      for (int i = 0; i < `PIO_FULL_LEVEL; i++)
         send_req(1'b1, rand_req(1 + int'($unsigned($random(seed)) % 3)));
      r = rand_req(1);
      queue_expect(1'b1, r);
      drive_req(1'b1, r);
      wait_accept(20, ok);
      if (ok) begin
         other_errs++;
         $display("%0t: read accepted with queue full", $time);
      end
      cons_en = 1'b1;
      @(negedge clk);
      wait_accept(ACC_LIMIT, ok);
      if (!ok) begin
         other_errs++;
         $display("%0t: held read not accepted after queue drained", $time);
      end
      release_req();
      wait_drain();

      // Read throttling with max_pio of 1 and completions held back
      auto_done = 1'b0;
      max_pio   = 4'd1;
      rd0       = rd_issued;
      wr0       = wr_issued;
      send_req(1'b1, rand_req(2));
      send_req(1'b1, rand_req(3));
      send_req(1'b1, rand_req(1));
      send_req(1'b0, rand_req(2));
      send_req(1'b1, rand_req(3));
      wait_cycles(40);
      check_val("reads issued", 64'(rd_issued - rd0), 64'd2);
      check_val("writes issued", 64'(wr_issued - wr0), 64'd0);
      check_val("pio_req", 64'(pio_req), 64'd0);
      done_owed = 1;
      wait_issued(rd0 + 3, wr0 + 1);
      wait_cycles(30);
      check_val("reads issued", 64'(rd_issued - rd0), 64'd3);
      check_val("pio_req", 64'(pio_req), 64'd0);
      done_owed = 1;
      wait_issued(rd0 + 4, wr0 + 1);
      done_owed = 2;
      wait_drain();

      check_val("csr_wr count", 64'(csr_wr_seen), 64'(csr_wr_sent));
      check_val("csr_rd_ack count", 64'(csr_ack_seen), 64'(csr_rd_sent));
      $display("Errors: %0d mismatches, %0d other failures", mis_errs, other_errs);
      if (mis_errs == 0 && other_errs == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/pio_req_top.sv */
// PIO request path top: accept, queue and issue stages in a chain
`timescale 1ns/1ps
`default_nettype none
`include "pio_macros.svh"

module pio_req_top import pio_pkg::*; (
   input  wire logic                  clk,
   input  wire logic                  rst,
   input  wire logic [3:0]            max_pio,
   // Request port
   input  wire logic                  rd_vld,
   input  wire logic                  wr_vld,
   input  wire ucb_req_t              req,
   output logic                       req_accepted,
   // CSR port
   output logic                       csr_wr,
   output csr_wr_t                    csr_wr_bus,
   output logic [`PIO_CSR_ADDR_W-1:0] csr_rd_addr,
   output logic                       csr_rd_ack,
   output logic [`PIO_THR_W-1:0]      csr_ack_thr,
   output logic [`PIO_BUF_W-1:0]      csr_ack_buf,
   // Consumer port
   input  wire logic                  pio_pop,
   input  wire logic                  rd_done,
   output logic                       pio_req,
   output logic                       pio_data_vld,
   output pio_out_t                   pio_out
);

   logic        q_full;
   logic        push;
   queue_word_t push_word;
   logic        pop;
   logic        head_vld;
   queue_word_t head_word;

   pio_accept pio_accept_inst (
      .clk          (clk),
      .rst          (rst),
      .rd_vld       (rd_vld),
      .wr_vld       (wr_vld),
      .req          (req),
      .q_full       (q_full),
      .req_accepted (req_accepted),
      .csr_wr       (csr_wr),
      .csr_wr_bus   (csr_wr_bus),
      .csr_rd_addr  (csr_rd_addr),
      .csr_rd_ack   (csr_rd_ack),
      .csr_ack_thr  (csr_ack_thr),
      .csr_ack_buf  (csr_ack_buf),
      .push         (push),
      .push_word    (push_word)
   );

   pio_queue pio_queue_inst (
      .clk       (clk),
      .rst       (rst),
      .push      (push),
      .push_word (push_word),
      .pop       (pop),
      .full      (q_full),
      .head_vld  (head_vld),
      .head_word (head_word)
   );

   pio_issue pio_issue_inst (
      .clk          (clk),
      .rst          (rst),
      .max_pio      (max_pio),
      .head_vld     (head_vld),
      .head_word    (head_word),
      .pio_pop      (pio_pop),
      .rd_done      (rd_done),
      .pop          (pop),
      .pio_req      (pio_req),
      .pio_data_vld (pio_data_vld),
      .pio_out      (pio_out)
   );

endmodule

`default_nettype wire

/* verilog/pio_issue.sv */
// PIO issue stage: head offer, byte enables and read throttling
`timescale 1ns/1ps
`default_nettype none
`include "pio_macros.svh"

module pio_issue import pio_pkg::*; (
   input  wire logic        clk,
   input  wire logic        rst,
   input  wire logic [3:0]  max_pio,
   input  wire logic        head_vld,
   input  wire queue_word_t head_word,
   input  wire logic        pio_pop,
   input  wire logic        rd_done,
   output logic             pop,
   output logic             pio_req,
   output logic             pio_data_vld,
   output pio_out_t         pio_out
);

   logic                   hdr_vld;
   logic                   stall_rd;
   logic                   rd_inc;
   logic [`PIO_PEND_W-1:0] pend_cnt;
   logic [`PIO_PEND_W-1:0] pend_nxt;
   logic [7:0]             pre_be;
   logic [7:0]             shift_be;
   logic [15:0]            be;

   // ********************
   // Head offer
   // ********************
   assign hdr_vld      = head_vld & ~head_word.is_data;
   assign pio_data_vld = head_vld & head_word.is_data;

   // Reads wait behind the throttle, writes never do
   assign pio_req = hdr_vld & ~(head_word.rw & stall_rd);

   // Drop stray pops on an empty head
   assign pop = pio_pop & head_vld;

   // ********************
   // Pending reads
   // ********************
   assign rd_inc   = pop & hdr_vld & head_word.rw;
   assign stall_rd = pend_cnt > {1'b0, max_pio};

   always_comb begin
      pend_nxt = pend_cnt;
      if (rd_inc & ~rd_done)
         pend_nxt = pend_cnt + 1'b1;
      else if (~rd_inc & rd_done & (pend_cnt != '0))
         pend_nxt = pend_cnt - 1'b1;
   end

   always_ff @(posedge clk) begin
      if (rst)
         pend_cnt <= '0;
      else
         pend_cnt <= pend_nxt;
   end

   // ********************
   // Byte enables
   // ********************
   always_comb begin
      case (head_word.size)
         `PIO_SIZE_1B: pre_be = 8'h01;
         `PIO_SIZE_2B: pre_be = 8'h03;
         `PIO_SIZE_4B: pre_be = 8'h0f;
         `PIO_SIZE_8B: pre_be = 8'hff;
         default:      pre_be = 8'hff;
      endcase
   end

   // Offset within the 8-byte lane
   assign shift_be = pre_be << head_word.payload.hdr.map_addr[2:0];

   always_comb begin
      if (head_word.dword)
         be = 16'hffff;
      else if (head_word.word_sel)
         be = {shift_be, 8'h00};
      else
         be = {8'h00, shift_be};
   end

   // Address or data, whichever the head word holds
   assign pio_out.rw     = head_word.rw;
   assign pio_out.dest   = head_word.dest;
   assign pio_out.be     = be;
   assign pio_out.ad     = head_word.payload.raw;
   assign pio_out.thr_id = head_word.thr_id;
   assign pio_out.buf_id = head_word.buf_id;

endmodule

`default_nettype wire

/* verilog/pio_queue.sv */
// PIO request queue: 16-word circular store with level and full flag
`timescale 1ns/1ps
`default_nettype none
`include "pio_macros.svh"

module pio_queue import pio_pkg::*; (
   input  wire logic        clk,
   input  wire logic        rst,
   input  wire logic        push,
   input  wire queue_word_t push_word,
   input  wire logic        pop,
   output logic             full,
   output logic             head_vld,
   output queue_word_t      head_word
);

   // Pointers carry one extra wrap bit
   logic [`PIO_QADDR_W:0] wptr;
   logic [`PIO_QADDR_W:0] rptr;
   logic [`PIO_QADDR_W:0] wptr_d1;
   logic [`PIO_QADDR_W:0] level;
   logic [`PIO_QADDR_W:0] level_nxt;

   queue_word_t mem [`PIO_QDEPTH];

   // ********************
   // Storage
   // ********************
   always_ff @(posedge clk) begin
      if (push)
         mem[wptr[`PIO_QADDR_W-1:0]] <= push_word;
   end

   assign head_word = mem[rptr[`PIO_QADDR_W-1:0]];

   // ********************
   // Pointers
   // ********************
   always_ff @(posedge clk) begin
      if (rst) begin
         wptr    <= '0;
         rptr    <= '0;
         wptr_d1 <= '0;
      end else begin
         if (push)
            wptr <= wptr + 1'b1;
         if (pop)
            rptr <= rptr + 1'b1;
         // Lagging copy so a fresh word settles before offer
         wptr_d1 <= wptr;
      end
   end

   assign head_vld = rptr != wptr_d1;

   // ********************
   // Level and full
   // ********************
   always_comb begin
      case ({push, pop})
         2'b10:   level_nxt = level + 1'b1;
         2'b01:   level_nxt = level - 1'b1;
         default: level_nxt = level;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst)
         level <= '0;
      else
         level <= level_nxt;
   end

   // Full one word early, write data beat always fits
   assign full = level >= (`PIO_QADDR_W+1)'(`PIO_FULL_LEVEL);

endmodule

`default_nettype wire

/* verilog/pio_accept.sv */
// PIO accept stage: push FSM, CSR window bypass and address remap
`timescale 1ns/1ps
`default_nettype none
`include "pio_macros.svh"

module pio_accept import pio_pkg::*; (
   input  wire logic                       clk,
   input  wire logic                       rst,
   input  wire logic                       rd_vld,
   input  wire logic                       wr_vld,
   input  wire ucb_req_t                   req,
   input  wire logic                       q_full,
   output logic                            req_accepted,
   output logic                            csr_wr,
   output csr_wr_t                         csr_wr_bus,
   output logic [`PIO_CSR_ADDR_W-1:0]      csr_rd_addr,
   output logic                            csr_rd_ack,
   output logic [`PIO_THR_W-1:0]           csr_ack_thr,
   output logic [`PIO_BUF_W-1:0]           csr_ack_buf,
   output logic                            push,
   output queue_word_t                     push_word
);

   // Push FSM encoding
   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_HDR  = 2'd1;
   localparam logic [1:0] ST_DATA = 2'd2;

   logic [1:0]            state;
   logic [1:0]            state_nxt;
   logic                  req_vld;
   logic                  csr_hit;
   logic                  in_idle;
   logic [`PIO_MAP_W-1:0] map_addr;
   logic [1:0]            dest;
   pio_payload_u          payload;

   // ********************
   // Push FSM
   // ********************
   assign req_vld = rd_vld | wr_vld;
   assign in_idle = state == ST_IDLE;

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            // CSR requests never enter the queue
            if (req_vld & ~csr_hit & ~q_full)
               state_nxt = ST_HDR;
         end
         ST_HDR: begin
            if (wr_vld)
               state_nxt = ST_DATA;
            else
               state_nxt = ST_IDLE;
         end
         ST_DATA: state_nxt = ST_IDLE;
         default: state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst)
         state <= ST_IDLE;
      else
         state <= state_nxt;
   end

   // Reads finish in header cycle, writes in data cycle, CSR at once
   assign req_accepted = (state == ST_HDR & ~wr_vld)
                       | (state == ST_DATA)
                       | (in_idle & req_vld & csr_hit);

   // ********************
   // CSR bypass
   // ********************
   assign csr_hit = req.addr[39:24] == 16'h80_00;

   assign csr_wr          = in_idle & wr_vld & csr_hit;
   assign csr_wr_bus.addr = req.addr[`PIO_CSR_ADDR_W-1:0];
   assign csr_wr_bus.data = req.data[`PIO_CSR_W-1:0];
   assign csr_rd_addr     = req.addr[`PIO_CSR_ADDR_W-1:0];

   // Read ack carries ids straight back
   assign csr_rd_ack  = in_idle & rd_vld & csr_hit;
   assign csr_ack_thr = req.thr_id;
   assign csr_ack_buf = req.buf_id;

   // ********************
   // Address decode
   // ********************
   always_comb begin
      if (req.addr[39:32] == 8'h80) begin
         if (req.addr[31:28] == 4'h0) begin
            // Low 256 MB of the 0x80 region
            map_addr = {15'h4000, req.addr[27:0]};
            if (req.addr[27:24] == 4'hE)
               dest = `PIO_DEST_4;
            else if (req.addr[27:24] == 4'hF)
               dest = `PIO_DEST_5;
            else
               dest = `PIO_DEST_OTH;
         end else begin
            map_addr = {11'h600, req.addr[31:0]};
            dest     = `PIO_DEST_0;
         end
      end else begin
         map_addr = {3'h7, req.addr};
         // Top quarter of address space, split by bit 37
         if (req.addr[39:38] == 2'b11)
            dest = req.addr[37] ? `PIO_DEST_5 : `PIO_DEST_4;
         else
            dest = `PIO_DEST_OTH;
      end
   end

   // Header beat gets the remapped address, data beat the raw data
   always_comb begin
      if (state == ST_DATA) begin
         payload.raw = req.data;
      end else begin
         payload.hdr.pad      = '0;
         payload.hdr.map_addr = map_addr;
      end
   end

   // ********************
   // Queue word
   // ********************
   assign push = (state == ST_HDR) | (state == ST_DATA);

   assign push_word.is_data  = state == ST_DATA;
   assign push_word.rw       = rd_vld;
   assign push_word.dest     = dest;
   assign push_word.thr_id   = req.thr_id;
   assign push_word.buf_id   = req.buf_id;
   assign push_word.size     = req.size;
   assign push_word.dword    = req.size == `PIO_SIZE_16B;
   assign push_word.word_sel = req.addr[3];
   assign push_word.payload  = payload;

endmodule

`default_nettype wire

/* verilog/pio_pkg.sv */
// PIO request path types: request, queue word, issue and CSR fields
`default_nettype none
`include "pio_macros.svh"

package pio_pkg;

   // One request from the request port
   typedef struct packed {
      logic [`PIO_THR_W-1:0]  thr_id;
      logic [`PIO_BUF_W-1:0]  buf_id;
      logic [`PIO_SIZE_W-1:0] size;
      logic [`PIO_ADDR_W-1:0] addr;
      logic [`PIO_DATA_W-1:0] data;
   } ucb_req_t;

   // Header view of a queue payload
   typedef struct packed {
      logic [`PIO_DATA_W-`PIO_MAP_W-1:0] pad;
      logic [`PIO_MAP_W-1:0]             map_addr;
   } pio_hdr_t;

   // Same 64 bits, either a remapped address or write data
   typedef union packed {
      pio_hdr_t                hdr;
      logic [`PIO_DATA_W-1:0]  raw;
   } pio_payload_u;

   // One queue entry
   typedef struct packed {
      logic                   is_data;
      logic                   rw;        // 1 = read
      logic [1:0]             dest;
      logic [`PIO_THR_W-1:0]  thr_id;
      logic [`PIO_BUF_W-1:0]  buf_id;
      logic [`PIO_SIZE_W-1:0] size;
      logic                   dword;     // 16-byte access
      logic                   word_sel;  // address bit 3
      pio_payload_u           payload;
   } queue_word_t;

   // Fields presented to the downstream consumer
   typedef struct packed {
      logic                   rw;
      logic [1:0]             dest;
      logic [15:0]            be;
      logic [`PIO_DATA_W-1:0] ad;
      logic [`PIO_THR_W-1:0]  thr_id;
      logic [`PIO_BUF_W-1:0]  buf_id;
   } pio_out_t;

   // CSR write strobe payload
   typedef struct packed {
      logic [`PIO_CSR_ADDR_W-1:0] addr;
      logic [`PIO_CSR_W-1:0]      data;
   } csr_wr_t;

endpackage

`default_nettype wire

/* verilog/pio_macros.svh */
// PIO request queue widths, depth, thresholds and encodings
`ifndef PIO_MACROS_SVH
`define PIO_MACROS_SVH

// Request port field widths
`define PIO_ADDR_W      40
`define PIO_MAP_W       43
`define PIO_DATA_W      64
`define PIO_THR_W       5
`define PIO_BUF_W       2
`define PIO_SIZE_W      3

// CSR port widths
`define PIO_CSR_ADDR_W  16
`define PIO_CSR_W       32

// Queue geometry
`define PIO_QDEPTH      16
`define PIO_QADDR_W     4
// Stop accepting here, one word kept for a write data beat
`define PIO_FULL_LEVEL  15

// Outstanding read counter
`define PIO_PEND_W      5

// Request size codes
`define PIO_SIZE_1B     3'd0
`define PIO_SIZE_2B     3'd1
`define PIO_SIZE_4B     3'd2
`define PIO_SIZE_8B     3'd3
`define PIO_SIZE_16B    3'd4

// Destination codes
`define PIO_DEST_0      2'd0
`define PIO_DEST_OTH    2'd1
`define PIO_DEST_4      2'd2
`define PIO_DEST_5      2'd3

`endif
